//--- Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert
TOP = controlUnitTb
FILELIST = controlUnit.f
PASS_MSG = Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- controlUnit.f
+incdir+rtl
rtl/isaPkg.sv
rtl/controlPkg.sv
rtl/instrDecoder.sv
rtl/controlSequencer.sv
rtl/controlWordTable.sv
rtl/controlUnit.sv
verification/controlChecker.sv
verification/controlUnitTb.sv

//--- rtl/controlPkg.sv
`include "control_defines.svh"

package controlPkg;

	typedef enum logic [`STATE_W-1:0] {
		stReset = 7'd0,
		stFetch = 7'd1,
		stDecode = 7'd2,
		stAdd = 7'd3,
		stSub = 7'd4,
		stAnd = 7'd5,
		stAddi = 7'd6,
		stJr = 7'd7,
		stAddiu = 7'd8,
		stJump = 7'd16,
		stCompare = 7'd50,
		stBranch = 7'd51,
		stJal = 7'd80,
		stWaitJal1 = 7'd81,
		stWaitJal2 = 7'd82,
		stWriteRa = 7'd83,
		stWait = 7'd91,
		stWriteIr = 7'd92,
		stWriteAluRd = 7'd93,
		stWriteAddiRd = 7'd94,
		stOverflow = 7'd100,
		stCause = 7'd101,
		stWriteCause = 7'd102
	} stateT;

	typedef enum logic [`REGDST_W-1:0] {
		dstRt = 3'd0,
		dstRd = 3'd1,
		dstRa = 3'd2,
		dstSp = 3'd3
	} regDstT;

	typedef enum logic [`ALUOP_W-1:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluCmp = 3'd7
	} aluOpT;

	typedef enum logic [`PCSRC_W-1:0] {
		pcAlu = 2'd0,
		pcTarget = 2'd1
	} pcSrcT;

	typedef struct packed {
		logic [`ADDRSRC_W-1:0] srcAddressMem;
		logic memOp;
		logic writeMdr;
		logic irWrite;
	} memCtrlT;

	typedef struct packed {
		regDstT regDst;
		logic regWrite;
		logic [`MEMTOREG_W-1:0] memToReg;
		logic writeA;
		logic writeB;
	} regCtrlT;

	typedef struct packed {
		logic [`ALUSRCA_W-1:0] aluSrcA;
		logic [`ALUSRCB_W-1:0] aluSrcB;
		aluOpT aluOp;
		logic writeAluOut;
	} aluCtrlT;

	typedef struct packed {
		pcSrcT pcSource;
		logic pcWrite;
		logic epcWrite;
	} pcCtrlT;

	typedef struct packed {
		memCtrlT memCtrl;
		regCtrlT regCtrl;
		aluCtrlT aluCtrl;
		pcCtrlT pcCtrl;
	} controlWordT;

endpackage

//--- rtl/controlSequencer.sv
`timescale 1ns/1ps
`include "control_defines.svh"

module controlSequencer
	import isaPkg::*;
	import controlPkg::*;
(
	input logic clk,
	input logic reset,
	input instrClassT instrClass,
	input logic branchTaken,
	input logic overflow,
	output stateT state
);

	stateT nextState;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stReset: nextState = stFetch;
			stFetch: nextState = stWait;
			stWait: nextState = stWriteIr; // memory read latency
			stWriteIr: nextState = stDecode;
			stDecode: begin
				case (instrClass)
					clsAdd: nextState = stAdd;
					clsSub: nextState = stSub;
					clsAnd: nextState = stAnd;
					clsJr: nextState = stJr;
					clsAddi: nextState = stAddi;
					clsAddiu: nextState = stAddiu;
					clsJ: nextState = stJump;
					clsJal: nextState = stJal;
					clsBranch: nextState = stCompare;
					default: nextState = stFetch; // unknown, skip it
				endcase
			end
			stAdd, stSub: nextState = overflow ? stOverflow : stWriteAluRd;
			stAddi, stAddiu: nextState = overflow ? stOverflow : stWriteAddiRd;
			stAnd: nextState = stWriteAluRd; // and cannot overflow
			stCompare: nextState = branchTaken ? stBranch : stFetch;
			stJal: nextState = stWaitJal1;
			stWaitJal1: nextState = stWaitJal2;
			stWaitJal2: nextState = stWriteRa;
			stWriteRa: nextState = stJump; // ra saved, now jump
			stOverflow: nextState = stCause;
			stCause: nextState = stWriteCause;
			default: nextState = stFetch;
		endcase
	end

	stateLegal: assert property (@(posedge clk) disable iff (reset)
		state inside {stReset, stFetch, stWait, stWriteIr, stDecode,
			stAdd, stSub, stAnd, stAddi, stAddiu, stJr, stJump,
			stCompare, stBranch, stWriteAluRd, stWriteAddiRd,
			stJal, stWaitJal1, stWaitJal2, stWriteRa,
			stOverflow, stCause, stWriteCause})
		else $error("illegal state %0d", state);

	irThenDecode: assert property (@(posedge clk) disable iff (reset)
		state == stWriteIr |=> state == stDecode)
		else $error("stWriteIr not followed by stDecode");

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`include "control_defines.svh"

module controlUnit
	import isaPkg::*;
	import controlPkg::*;
(
	input logic clk,
	input logic reset,
	input opcodeT opcode,
	input functT funct,
	input logic overflow,
	input logic eq,
	input logic gt,
	output controlWordT ctrl
);

	instrClassT instrClass;
	logic branchTaken;
	stateT state;

	instrDecoder decoder (
		.opcode(opcode),
		.funct(funct),
		.eq(eq),
		.gt(gt),
		.instrClass(instrClass),
		.branchTaken(branchTaken)
	);

	controlSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.branchTaken(branchTaken),
		.overflow(overflow),
		.state(state)
	);

	controlWordTable wordTable (
		.state(state),
		.ctrl(ctrl)
	);

endmodule

//--- rtl/controlWordTable.sv
`timescale 1ns/1ps
`include "control_defines.svh"

module controlWordTable
	import controlPkg::*;
(
	input stateT state,
	output controlWordT ctrl
);

	always_comb begin
		ctrl = '0;
		case (state)
			stReset: begin
				ctrl.regCtrl.regDst = dstSp;
				ctrl.regCtrl.regWrite = 1'b1;
				ctrl.regCtrl.memToReg = 3'd7; // stack top constant
			end
			stFetch: begin
				ctrl.memCtrl.writeMdr = 1'b1;
				ctrl.aluCtrl.aluSrcB = 3'd1; // pc + 4
				ctrl.aluCtrl.aluOp = aluAdd;
				ctrl.aluCtrl.writeAluOut = 1'b1;
				ctrl.pcCtrl.pcSource = pcAlu;
				ctrl.pcCtrl.pcWrite = 1'b1;
			end
			stWriteIr: ctrl.memCtrl.irWrite = 1'b1;
			stDecode: begin
				ctrl.regCtrl.writeA = 1'b1;
				ctrl.regCtrl.writeB = 1'b1;
				ctrl.aluCtrl.aluSrcB = 3'd3; // branch offset, computed early
				ctrl.aluCtrl.aluOp = aluAdd;
				ctrl.aluCtrl.writeAluOut = 1'b1;
			end
			stAdd, stSub, stAnd: begin
				ctrl.aluCtrl.aluSrcA = 2'd1;
				ctrl.aluCtrl.aluSrcB = 3'd0;
				ctrl.aluCtrl.writeAluOut = 1'b1;
				case (state)
					stSub: ctrl.aluCtrl.aluOp = aluSub;
					stAnd: ctrl.aluCtrl.aluOp = aluAnd;
					default: ctrl.aluCtrl.aluOp = aluAdd;
				endcase
			end
			stAddi, stAddiu: begin
				ctrl.aluCtrl.aluSrcA = 2'd1;
				// sign vs zero extended immediate
				ctrl.aluCtrl.aluSrcB = (state == stAddi) ? 3'd2 : 3'd4;
				ctrl.aluCtrl.aluOp = aluAdd;
				ctrl.aluCtrl.writeAluOut = 1'b1;
			end
			stJr: begin
				ctrl.aluCtrl.aluSrcA = 2'd1; // rs straight through
				ctrl.aluCtrl.aluOp = aluPass;
				ctrl.aluCtrl.writeAluOut = 1'b1;
				ctrl.pcCtrl.pcSource = pcAlu;
				ctrl.pcCtrl.pcWrite = 1'b1;
			end
			stJump, stBranch, stWriteCause: begin
				ctrl.pcCtrl.pcSource = pcTarget;
				ctrl.pcCtrl.pcWrite = 1'b1;
			end
			stCompare: begin
				ctrl.aluCtrl.aluSrcA = 2'd1;
				ctrl.aluCtrl.aluSrcB = 3'd0;
				ctrl.aluCtrl.aluOp = aluCmp; // sets eq and gt
			end
			stWriteAluRd: begin
				ctrl.regCtrl.regDst = dstRd;
				ctrl.regCtrl.regWrite = 1'b1;
			end
			stWriteAddiRd: begin
				ctrl.regCtrl.regDst = dstRt;
				ctrl.regCtrl.regWrite = 1'b1;
			end
			stJal: ctrl.regCtrl.memToReg = 3'd1; // return address
			stWaitJal2: ctrl.memCtrl.writeMdr = 1'b1;
			stWriteRa: begin
				ctrl.regCtrl.regDst = dstRa;
				ctrl.regCtrl.regWrite = 1'b1;
				ctrl.regCtrl.memToReg = 3'd1;
			end
			stOverflow: begin
				ctrl.aluCtrl.aluSrcB = 3'd1; // pc - 4 into epc
				ctrl.aluCtrl.aluOp = aluSub;
				ctrl.aluCtrl.writeAluOut = 1'b1;
				ctrl.pcCtrl.epcWrite = 1'b1;
			end
			stCause: begin
				ctrl.memCtrl.srcAddressMem = `CAUSE_SLOT;
				ctrl.memCtrl.writeMdr = 1'b1;
				ctrl.aluCtrl.aluSrcA = 2'd3; // handler address from mdr
				ctrl.aluCtrl.writeAluOut = 1'b1;
			end
			default: ctrl = '0; // wait states and unused codes
		endcase
	end

	always_comb begin
		assert (!(ctrl.memCtrl.irWrite && ctrl.pcCtrl.pcWrite))
			else $error("irWrite and pcWrite together in state %0d", state);
		assert (!ctrl.pcCtrl.epcWrite || ctrl.aluCtrl.writeAluOut)
			else $error("epcWrite without writeAluOut in state %0d", state);
	end

endmodule

//--- rtl/control_defines.svh
`ifndef CONTROL_DEFINES_SVH
`define CONTROL_DEFINES_SVH

// instruction register fields
`define OPCODE_W 6
`define FUNCT_W 6

// state register width
`define STATE_W 7

// datapath select widths
`define REGDST_W 3
`define MEMTOREG_W 3
`define ALUSRCB_W 3
`define ALUSRCA_W 2
`define ALUOP_W 3
`define PCSRC_W 2
`define ADDRSRC_W 3

// memory slot that holds the overflow handler address
`define CAUSE_SLOT 3'd3

`endif

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
`include "control_defines.svh"

module instrDecoder
	import isaPkg::*;
(
	input opcodeT opcode,
	input functT funct,
	input logic eq,
	input logic gt,
	output instrClassT instrClass,
	output logic branchTaken
);

	always_comb begin
		instrClass = clsUnknown;
		case (opcode)
			opR: begin
				case (funct)
					fnAdd: instrClass = clsAdd;
					fnSub: instrClass = clsSub;
					fnAnd: instrClass = clsAnd;
					fnJr: instrClass = clsJr;
					default: instrClass = clsUnknown; // unsupported funct
				endcase
			end
			opAddi: instrClass = clsAddi;
			opAddiu: instrClass = clsAddiu;
			opJ: instrClass = clsJ;
			opJal: instrClass = clsJal;
			opBeq, opBne, opBle, opBgt: instrClass = clsBranch;
			default: instrClass = clsUnknown;
		endcase
	end

	// condition only matters while in compare
	always_comb begin
		case (opcode)
			opBeq: branchTaken = eq;
			opBne: branchTaken = !eq;
			opBle: branchTaken = !gt;
			opBgt: branchTaken = gt;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- rtl/isaPkg.sv
`include "control_defines.svh"

package isaPkg;

	typedef enum logic [`OPCODE_W-1:0] {
		opR = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opBle = 6'h06,
		opBgt = 6'h07,
		opAddi = 6'h08,
		opAddiu = 6'h09
	} opcodeT;

	typedef enum logic [`FUNCT_W-1:0] {
		fnJr = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24
	} functT;

	// what the sequencer needs to know after decode
	typedef enum logic [3:0] {
		clsAdd,
		clsSub,
		clsAnd,
		clsJr,
		clsAddi,
		clsAddiu,
		clsJ,
		clsJal,
		clsBranch,
		clsUnknown
	} instrClassT;

endpackage

//--- verification/controlChecker.sv
`timescale 1ns/1ps

module controlChecker
	import controlPkg::*;
(
	input logic clk,
	input logic reset,
	input controlWordT ctrl,
	input logic expValid,
	input int expLen,
	input int expRegDst,
	input int expPcWrites,
	output int errorCount,
	output int checkedCount
);

	localparam int noRegWrite = 7;

	logic armed;
	int wantLen;
	int wantDst;
	int wantPc;
	int cycles;
	int regWrites;
	int pcWrites;
	int epcWrites;
	int seenDst;
	logic inResetCycle;
	logic sawFirstIr;
	int sinceReset;

	// stack pointer load is the only active control in reset
	function automatic controlWordT resetWord();
		controlWordT w;
		w = '0;
		w.regCtrl.regDst = dstSp;
		w.regCtrl.regWrite = 1'b1;
		w.regCtrl.memToReg = 3'd7;
		return w;
	endfunction

	task automatic reportMismatch(input string what, input int got, input int want);
		$display("mismatch at %0t: instruction %0d %s is %0d, expected %0d",
			$time, checkedCount, what, got, want);
		errorCount++;
	endtask

	task automatic compareWindow();
		int wantRegWrites;
		int wantEpc;
		wantRegWrites = (wantDst == noRegWrite) ? 0 : 1;
		wantEpc = (wantLen == 8) ? 1 : 0; // only the overflow path is 8 long
		if (cycles != wantLen)
			reportMismatch("length", cycles, wantLen);
		if (regWrites != wantRegWrites)
			reportMismatch("regWrite count", regWrites, wantRegWrites);
		else if (wantRegWrites == 1 && seenDst != wantDst)
			reportMismatch("regDst", seenDst, wantDst);
		if (pcWrites != wantPc)
			reportMismatch("pcWrite count", pcWrites, wantPc);
		if (epcWrites != wantEpc)
			reportMismatch("epcWrite count", epcWrites, wantEpc);
		checkedCount++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			errorCount = 0;
			checkedCount = 0;
			armed = 1'b0;
			inResetCycle = 1'b1;
			sawFirstIr = 1'b0;
			sinceReset = 0;
			cycles = 0;
		end else begin
			if (inResetCycle) begin
				inResetCycle = 1'b0;
				if (ctrl !== resetWord()) begin
					$display("mismatch at %0t: reset control word %h, expected %h",
						$time, ctrl, resetWord());
					errorCount++;
				end
			end else if (!sawFirstIr) begin
				sinceReset++;
			end
			cycles++;
			if (ctrl.regCtrl.regWrite) begin
				regWrites++;
				seenDst = int'(ctrl.regCtrl.regDst);
			end
			if (ctrl.pcCtrl.pcWrite)
				pcWrites++;
			if (ctrl.pcCtrl.epcWrite)
				epcWrites++;
			if (ctrl.memCtrl.irWrite) begin
				if (!sawFirstIr && sinceReset > 3) begin
					$display("first irWrite came %0d cycles after reset, at most 3 allowed",
						sinceReset);
					errorCount++;
				end
				sawFirstIr = 1'b1;
				if (armed)
					compareWindow();
				armed = expValid; // next window belongs to the line just applied
				wantLen = expLen;
				wantDst = expRegDst;
				wantPc = expPcWrites;
				cycles = 0;
				regWrites = 0;
				pcWrites = 0;
				epcWrites = 0;
				seenDst = noRegWrite;
			end
		end
	end

endmodule

//--- verification/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb
	import isaPkg::*;
	import controlPkg::*;
();

	localparam int timeoutCycles = 20;

	logic clk;
	logic reset;
	opcodeT opcode;
	functT funct;
	logic overflow;
	logic eq;
	logic gt;
	controlWordT ctrl;

	logic expValid;
	int expLen;
	int expRegDst;
	int expPcWrites;
	int errorCount;
	int checkedCount;
	int timeoutCount;
	int otherCount;
	int vectorCount;
	int fd;
	logic [8*160-1:0] lineBuf;

	controlUnit dut (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.overflow(overflow),
		.eq(eq),
		.gt(gt),
		.ctrl(ctrl)
	);

	controlChecker ctrlCheck (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.expValid(expValid),
		.expLen(expLen),
		.expRegDst(expRegDst),
		.expPcWrites(expPcWrites),
		.errorCount(errorCount),
		.checkedCount(checkedCount)
	);

	always #4 clk = ~clk;

	// returns on the falling edge of an irWrite cycle
	task automatic waitForIrWrite(output logic found);
		int i;
		found = 1'b0;
		for (i = 0; i < timeoutCycles && !found; i++) begin
			@(negedge clk);
			found = ctrl.memCtrl.irWrite;
		end
		if (!found) begin
			$display("timeout: no irWrite within %0d cycles at %0t", timeoutCycles, $time);
			timeoutCount++;
		end
	endtask

	initial begin
		logic found;
		logic running;
		int fields;
		int vOp, vFunct, vOvf, vEq, vGt;
		int vLen, vDst, vPc;
		clk = 1'b0;
		reset = 1'b1;
		opcode = opR;
		funct = fnAdd;
		overflow = 1'b0;
		eq = 1'b0;
		gt = 1'b0;
		expValid = 1'b0;
		expLen = 0;
		expRegDst = 7;
		expPcWrites = 0;
		timeoutCount = 0;
		otherCount = 0;
		vectorCount = 0;
		fd = $fopen("verification/control_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/control_vectors.txt");
			otherCount++;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		running = (fd != 0);
		while (running) begin
			lineBuf = '0;
			if ($fgets(lineBuf, fd) == 0) begin
				running = 1'b0;
			end else begin
				fields = $sscanf(lineBuf, "%h %h %h %h %h %d %d %d",
					vOp, vFunct, vOvf, vEq, vGt, vLen, vDst, vPc);
				if (fields == 8) begin // header and blank lines give fewer
					waitForIrWrite(found);
					if (!found) begin
						running = 1'b0;
					end else begin
						opcode = opcodeT'(vOp[5:0]);
						funct = functT'(vFunct[5:0]);
						overflow = vOvf[0];
						eq = vEq[0];
						gt = vGt[0];
						expLen = vLen;
						expRegDst = vDst;
						expPcWrites = vPc;
						expValid = 1'b1;
						vectorCount++;
					end
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
			if (timeoutCount == 0) begin
				waitForIrWrite(found); // closes the last instruction
				expValid = 1'b0;
				@(negedge clk);
			end
		end
		if (vectorCount == 0 || checkedCount != vectorCount) begin
			$display("only %0d of %0d vectors were checked", checkedCount, vectorCount);
			otherCount++;
		end
		$display("checked %0d: %0d mismatches, %0d timeouts, %0d other errors",
			checkedCount, errorCount, timeoutCount, otherCount);
		if (errorCount == 0 && timeoutCount == 0 && otherCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- verification/control_vectors.txt
# opcode funct overflow eq gt in hex then length regDst pcWrites in decimal
# regDst 7 means no regWrite in the instruction
00 20 0 0 0 6 1 1
00 22 0 0 0 6 1 1
00 24 0 0 0 6 1 1
08 00 0 0 0 6 0 1
09 00 0 0 0 6 0 1
00 20 1 0 0 8 7 2
00 22 1 0 0 8 7 2
08 00 1 0 0 8 7 2
09 00 1 0 0 8 7 2
00 24 1 0 0 6 1 1
04 00 0 1 0 6 7 2
04 00 0 0 0 5 7 1
05 00 0 0 0 6 7 2
05 00 0 1 0 5 7 1
06 00 0 0 0 6 7 2
06 00 0 0 1 5 7 1
07 00 0 0 1 6 7 2
07 00 0 0 0 5 7 1
02 00 0 0 0 5 7 2
00 08 0 0 0 5 7 2
03 00 0 0 0 9 2 2
3f 00 0 0 0 4 7 1
00 2a 0 0 0 4 7 1
